// ==== all.f ====
hw/decodePkg.sv
hw/ctrlIf.sv
hw/instLatch.sv
hw/contrGen.sv
hw/immGen.sv
hw/decodeReg.sv
hw/decodeUnit.sv
tb/clockGen.sv
tb/decodeTb.sv

// ==== hw/contrGen.sv ====
module contrGen (
    input  logic [31:0]       inst,
    ctrlIf.gen                ctrl,
    output decodePkg::immFmtT immFmt
);
    import decodePkg::*;

    logic [6:0] func7;
    logic [2:0] func3;
    opcodeT     opcode;
    logic       legal;
    immFmtT     fmt;
    aluOpT      aluSel;
    aSrcT       aSel;
    bSrcT       bSel;
    branchT     brSel;
    branchT     brKind;
    memOpT      memSel;
    memOpT      storeMem;
    regSrcT     wbSel;
    logic       storeOp;
    logic       wordOp;
    logic       sysOp;

    assign func7  = inst[31:25];
    assign func3  = inst[14:12];
    assign opcode = opcodeT'(inst[6:0]);

    // supported instruction list, anything else is illegal
    always_comb begin
        casez ({func7, func3, opcode})
            17'b???????_000_0010011, 17'b???????_011_0010011,  // addi sltiu
            17'b???????_100_0010011, 17'b???????_110_0010011,  // xori ori
            17'b???????_111_0010011, 17'b000000?_001_0010011,  // andi slli
            17'b000000?_101_0010011, 17'b010000?_101_0010011,  // srli srai
            17'b???????_000_0011011, 17'b0000000_001_0011011,  // addiw slliw
            17'b0000000_101_0011011, 17'b0100000_101_0011011,  // srliw sraiw
            17'b0000000_000_0110011, 17'b0100000_000_0110011,  // add sub
            17'b0000000_001_0110011, 17'b0000000_010_0110011,  // sll slt
            17'b0000000_011_0110011, 17'b0000000_100_0110011,  // sltu xor
            17'b0000000_110_0110011, 17'b0000000_111_0110011,  // or and
            17'b0000001_000_0110011, 17'b0000001_101_0110011,  // mul divu
            17'b0000001_111_0110011,                           // remu
            17'b0000000_000_0111011, 17'b0100000_000_0111011,  // addw subw
            17'b0000000_001_0111011, 17'b0000000_101_0111011,  // sllw srlw
            17'b0100000_101_0111011, 17'b0000001_000_0111011,  // sraw mulw
            17'b0000001_100_0111011, 17'b0000001_101_0111011,  // divw divuw
            17'b0000001_110_0111011,                           // remw
            17'b???????_???_0010111, 17'b???????_???_0110111,  // auipc lui
            17'b???????_???_1101111, 17'b???????_000_1100111,  // jal jalr
            17'b???????_000_0000011, 17'b???????_001_0000011,  // lb lh
            17'b???????_010_0000011, 17'b???????_011_0000011,  // lw ld
            17'b???????_100_0000011, 17'b???????_101_0000011,  // lbu lhu
            17'b???????_110_0000011,                           // lwu
            17'b???????_000_0100011, 17'b???????_001_0100011,  // sb sh
            17'b???????_010_0100011, 17'b???????_011_0100011,  // sw sd
            17'b???????_000_1100011, 17'b???????_001_1100011,  // beq bne
            17'b???????_100_1100011, 17'b???????_101_1100011,  // blt bge
            17'b???????_110_1100011, 17'b???????_111_1100011,  // bltu bgeu
            17'b???????_???_1110011:                           // ecall mret csr group
                legal = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    // func3 driven sub-decodes for branches and stores
    always_comb begin
        case (func3)
            3'b000:  brKind = BR_EQ;
            3'b001:  brKind = BR_NE;
            3'b100:  brKind = BR_LT;
            3'b101:  brKind = BR_GE;
            3'b110:  brKind = BR_LTU;
            3'b111:  brKind = BR_GEU;
            default: brKind = BR_NONE;
        endcase
        case (func3)
            3'b000:  storeMem = MEM_BU;  // sb
            3'b001:  storeMem = MEM_HU;  // sh
            3'b010:  storeMem = MEM_WU;  // sw
            3'b011:  storeMem = MEM_D;   // sd
            default: storeMem = MEM_NONE;
        endcase
    end

    always_comb begin
        fmt     = FMT_NONE;
        aluSel  = ALU_ADD;
        aSel    = A_RS1;
        bSel    = B_IMM;
        brSel   = BR_NONE;
        memSel  = MEM_NONE;
        wbSel   = RS_ALU;
        storeOp = 1'b0;
        wordOp  = 1'b0;
        sysOp   = 1'b0;
        case (opcode)
            OP, OP32: begin
                fmt    = FMT_R;
                aluSel = aluOpT'({func7[0], func7[5], func3});
                bSel   = B_RS2;
                wordOp = (opcode == OP32);
            end
            OP_IMM, OP_IMM32: begin
                fmt    = FMT_I;
                aluSel = aluOpT'({1'b0, func7[5] & (func3 == 3'b101), func3});  // sra vs srl
                wordOp = (opcode == OP_IMM32);
            end
            LOAD: begin
                fmt    = FMT_I;
                memSel = memOpT'(~func3);  // lb..lwu map to 7 - func3
                wbSel  = RS_MEM;
            end
            STORE: begin
                fmt     = FMT_S;
                memSel  = storeMem;
                storeOp = 1'b1;
            end
            BRANCH: begin
                fmt    = FMT_B;
                aluSel = ALU_SUB;  // compare by subtraction
                bSel   = B_RS2;
                brSel  = brKind;
            end
            LUI: begin
                fmt    = FMT_U;
                aluSel = ALU_PASSB;
                aSel   = A_PC;
            end
            AUIPC: begin
                fmt  = FMT_U;
                aSel = A_PC;
            end
            JAL, JALR: begin
                fmt   = (opcode == JAL) ? FMT_J : FMT_I;
                aSel  = A_PC;
                bSel  = B_FOUR;
                brSel = (opcode == JAL) ? BR_JAL : BR_JALR;
            end
            SYSTEM: begin
                fmt   = FMT_I;
                aSel  = A_PC;
                wbSel = RS_CSR;
                sysOp = 1'b1;
            end
            default: ;
        endcase
        // illegal words leave with all-zero encodings
        if (!legal) begin
            fmt     = FMT_NONE;
            aluSel  = ALU_ADD;
            aSel    = A_PC;
            bSel    = B_IMM;
            brSel   = BR_NONE;
            memSel  = MEM_NONE;
            wbSel   = RS_ALU;
            storeOp = 1'b0;
            wordOp  = 1'b0;
            sysOp   = 1'b0;
        end
    end

    assign immFmt          = fmt;
    assign ctrl.immFmt     = fmt;
    assign ctrl.aluOp      = aluSel;
    assign ctrl.aSrc       = aSel;
    assign ctrl.bSrc       = bSel;
    assign ctrl.branch     = brSel;
    assign ctrl.regWr      = fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};
    assign ctrl.memWr      = storeOp;
    assign ctrl.memOp      = memSel;
    assign ctrl.regSrc     = wbSel;
    assign ctrl.isTruncate = wordOp;  // w ops truncate and sign extend together
    assign ctrl.isSext     = wordOp;
    assign ctrl.intrEn     = sysOp;
    assign ctrl.illegal    = !legal;

    // no architectural write may escape from an unknown encoding
    always_comb begin
        assert (!(ctrl.illegal && (ctrl.regWr || ctrl.memWr)))
            else $error("illegal encoding carries a write enable");
    end

endmodule

// ==== hw/ctrlIf.sv ====
interface ctrlIf #(
    parameter int XLEN = 64
);
    import decodePkg::*;

    immFmtT          immFmt;
    aluOpT           aluOp;
    aSrcT            aSrc;
    bSrcT            bSrc;
    branchT          branch;
    logic            regWr;
    logic            memWr;
    memOpT           memOp;
    regSrcT          regSrc;
    logic            isTruncate;  // keep low 32 bits of the result
    logic            isSext;      // then sign extend them
    logic            intrEn;
    logic            illegal;
    logic [XLEN-1:0] imm;

    // contrGen and immGen share this side
    modport gen (
        output immFmt, aluOp, aSrc, bSrc, branch, regWr, memWr, memOp,
        output regSrc, isTruncate, isSext, intrEn, illegal, imm
    );

    modport sink (
        input immFmt, aluOp, aSrc, bSrc, branch, regWr, memWr, memOp,
        input regSrc, isTruncate, isSext, intrEn, illegal, imm
    );

endinterface

// ==== hw/decodePkg.sv ====
package decodePkg;

    // major opcodes, standard RV64 encodings
    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        OP_IMM   = 7'b0010011,
        AUIPC    = 7'b0010111,
        OP_IMM32 = 7'b0011011,
        STORE    = 7'b0100011,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        OP32     = 7'b0111011,
        BRANCH   = 7'b1100011,
        JALR     = 7'b1100111,
        JAL      = 7'b1101111,
        SYSTEM   = 7'b1110011
    } opcodeT;

    // immediate format, numbered as the old Extop field
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_S    = 3'd3,
        FMT_B    = 3'd4,
        FMT_U    = 3'd5,
        FMT_J    = 3'd6
    } immFmtT;

    // R-type code is {mul, func7[5], func3}, only the odd ones are named
    typedef enum logic [4:0] {
        ALU_ADD   = 5'd0,
        ALU_SUB   = 5'd8,
        ALU_PASSB = 5'd9  // no R-type instruction lands here
    } aluOpT;

    typedef enum logic {
        A_PC  = 1'b0,
        A_RS1 = 1'b1
    } aSrcT;

    typedef enum logic [1:0] {
        B_IMM  = 2'd0,
        B_RS2  = 2'd1,
        B_FOUR = 2'd2  // link address pc + 4
    } bSrcT;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_LT   = 4'd3,
        BR_GE   = 4'd4,
        BR_LTU  = 4'd5,
        BR_GEU  = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } branchT;

    // stores reuse the low codes, sw 1 sh 2 sb 3 sd 4
    typedef enum logic [2:0] {
        MEM_NONE = 3'd0,
        MEM_WU   = 3'd1,
        MEM_HU   = 3'd2,
        MEM_BU   = 3'd3,
        MEM_D    = 3'd4,
        MEM_W    = 3'd5,
        MEM_H    = 3'd6,
        MEM_B    = 3'd7
    } memOpT;

    typedef enum logic [1:0] {
        RS_ALU = 2'd0,
        RS_MEM = 2'd1,
        RS_CSR = 2'd2
    } regSrcT;

endpackage

// ==== hw/decodeReg.sv ====
module decodeReg #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            latched,
    input  logic [XLEN-1:0] latchedPc,
    ctrlIf.sink             ctrl,
    output logic            outValid,
    output logic            illegal,
    output logic [4:0]      aluOp,
    output logic            aSrc,
    output logic [1:0]      bSrc,
    output logic [3:0]      branch,
    output logic            regWr,
    output logic            memWr,
    output logic [2:0]      memOp,
    output logic [1:0]      regSrc,
    output logic            isTruncate,
    output logic            isSext,
    output logic            intrEn,
    output logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] pcOut
);
    import decodePkg::*;

    // valid pulse and the flags that cause side effects
    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
            illegal  <= 1'b0;
            regWr    <= 1'b0;
            memWr    <= 1'b0;
            intrEn   <= 1'b0;
        end else begin
            outValid <= latched;
            if (latched) begin
                illegal <= ctrl.illegal;
                regWr   <= ctrl.regWr;
                memWr   <= ctrl.memWr;
                intrEn  <= ctrl.intrEn;
            end
        end
    end

    // payload holds between instructions
    always_ff @(posedge clk) begin
        if (latched) begin
            aluOp      <= ctrl.aluOp;
            aSrc       <= ctrl.aSrc;
            bSrc       <= ctrl.bSrc;
            branch     <= ctrl.branch;
            memOp      <= ctrl.memOp;
            regSrc     <= ctrl.regSrc;
            isTruncate <= ctrl.isTruncate;
            isSext     <= ctrl.isSext;
            imm        <= ctrl.imm;
            pcOut      <= latchedPc;
        end
    end

    validFromLatch: assert property (
        @(posedge clk) disable iff (reset)
        outValid |-> $past(latched)
    ) else $error("outValid without a latched instruction");

    // every legal word has a format, and only illegal words have none
    fmtMatchesIllegal: assert property (
        @(posedge clk) disable iff (reset)
        latched |-> (ctrl.illegal == (ctrl.immFmt == FMT_NONE))
    ) else $error("immediate format disagrees with illegal flag");

endmodule

// ==== hw/decodeUnit.sv ====
module decodeUnit #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            instValid,
    input  logic [31:0]     inst,
    input  logic [XLEN-1:0] pc,
    output logic            outValid,
    output logic            illegal,
    output logic [4:0]      aluOp,
    output logic            aSrc,
    output logic [1:0]      bSrc,
    output logic [3:0]      branch,
    output logic            regWr,
    output logic            memWr,
    output logic [2:0]      memOp,
    output logic [1:0]      regSrc,
    output logic            isTruncate,
    output logic            isSext,
    output logic            intrEn,
    output logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] pcOut
);
    import decodePkg::*;

    logic [31:0]     latchedInst;
    logic [XLEN-1:0] latchedPc;
    logic            latched;
    immFmtT          immFmt;

    ctrlIf #(.XLEN(XLEN)) ctrl ();

    // cycle N+1: captured word
    instLatch #(.XLEN(XLEN)) latchU (
        .clk         (clk),
        .reset       (reset),
        .instValid   (instValid),
        .inst        (inst),
        .pc          (pc),
        .latchedInst (latchedInst),
        .latchedPc   (latchedPc),
        .latched     (latched)
    );

    // combinational decode within cycle N+1
    contrGen genU (
        .inst   (latchedInst),
        .ctrl   (ctrl.gen),
        .immFmt (immFmt)
    );

    immGen #(.XLEN(XLEN)) immU (
        .inst   (latchedInst),
        .immFmt (immFmt),
        .ctrl   (ctrl.gen)
    );

    // cycle N+2: registered outputs
    decodeReg #(.XLEN(XLEN)) outU (
        .clk        (clk),
        .reset      (reset),
        .latched    (latched),
        .latchedPc  (latchedPc),
        .ctrl       (ctrl.sink),
        .outValid   (outValid),
        .illegal    (illegal),
        .aluOp      (aluOp),
        .aSrc       (aSrc),
        .bSrc       (bSrc),
        .branch     (branch),
        .regWr      (regWr),
        .memWr      (memWr),
        .memOp      (memOp),
        .regSrc     (regSrc),
        .isTruncate (isTruncate),
        .isSext     (isSext),
        .intrEn     (intrEn),
        .imm        (imm),
        .pcOut      (pcOut)
    );

endmodule

// ==== hw/immGen.sv ====
module immGen #(
    parameter int XLEN = 64
) (
    input  logic [31:0]       inst,
    input  decodePkg::immFmtT immFmt,
    ctrlIf.gen                ctrl
);
    import decodePkg::*;

    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immJ;

    // inst[31] is the sign bit in every format
    assign immI = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign immS = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (immFmt)
            FMT_I:   ctrl.imm = immI;
            FMT_S:   ctrl.imm = immS;
            FMT_B:   ctrl.imm = immB;
            FMT_U:   ctrl.imm = immU;
            FMT_J:   ctrl.imm = immJ;
            default: ctrl.imm = '0;  // R type and illegal words
        endcase
    end

endmodule

// ==== hw/instLatch.sv ====
module instLatch #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            instValid,
    input  logic [31:0]     inst,
    input  logic [XLEN-1:0] pc,
    output logic [31:0]     latchedInst,
    output logic [XLEN-1:0] latchedPc,
    output logic            latched
);

    // one-cycle valid level behind the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            latched <= 1'b0;
        end else begin
            latched <= instValid;
        end
    end

    // word and pc only move on a strobe, so they hold otherwise
    always_ff @(posedge clk) begin
        if (instValid) begin
            latchedInst <= inst;
            latchedPc   <= pc;
        end
    end

    // a floating word here would poison every decoded field downstream
    latchedKnown: assert property (
        @(posedge clk) disable iff (reset)
        latched |-> !$isunknown(latchedInst)
    ) else $error("latched instruction word has unknown bits");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module decodeTb -Mdir obj_dir -o decodeSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/decodeSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== tb/clockGen.sv ====
module clockGen #(
    parameter int period      = 20,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // released just after an edge, like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

// ==== tb/decodeTb.sv ====
module decodeTb;
    import decodePkg::*;

    // one row of the stimulus table
    typedef struct packed {
        logic [31:0] word;
        logic [63:0] imm;
        logic [4:0]  aluOp;
        logic        aSrc;
        logic [1:0]  bSrc;
        logic [3:0]  branch;
        logic [2:0]  memOp;
        logic [1:0]  regSrc;
        logic [4:0]  flags;  // regWr memWr word intrEn illegal
    } caseT;

    typedef struct packed {
        caseT        exp;
        logic [63:0] pc;
        int          due;  // cycle in which outValid must be seen
    } pendT;

    logic        clk;
    logic        reset;
    logic        instValid;
    logic [31:0] inst;
    logic [63:0] pc;
    logic        outValid;
    logic        illegal;
    logic [4:0]  aluOp;
    logic        aSrc;
    logic [1:0]  bSrc;
    logic [3:0]  branch;
    logic        regWr;
    logic        memWr;
    logic [2:0]  memOp;
    logic [1:0]  regSrc;
    logic        isTruncate;
    logic        isSext;
    logic        intrEn;
    logic [63:0] imm;
    logic [63:0] pcOut;

    caseT cases[$];
    pendT pending[$];
    int   cycleCount = 0;
    logic seenOut    = 1'b0;
    logic tableReady = 1'b0;

    clockGen #(.period(20), .resetCycles(3)) clockU (.clk(clk), .reset(reset));

    decodeUnit #(.XLEN(64)) decodeUnit_inst (.*);

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic failWith(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkField(input string name, input logic [63:0] got, input logic [63:0] want);
        assert (got === want)
            else failWith($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, want));
    endtask

    task automatic addCase(input logic [31:0] word, input longint immVal, input logic [4:0] alu,
                           input logic a, input logic [1:0] b, input logic [3:0] br,
                           input logic [2:0] mem, input logic [1:0] rs, input logic [4:0] flags);
        caseT c;
        c.word   = word;
        c.imm    = immVal;
        c.aluOp  = alu;
        c.aSrc   = a;
        c.bSrc   = b;
        c.branch = br;
        c.memOp  = mem;
        c.regSrc = rs;
        c.flags  = flags;
        cases.push_back(c);
    endtask

    // rd x1, rs1 x2, rs2 x3 throughout
    task automatic buildTable();
        addCase(32'h003100b3, 0, ALU_ADD, A_RS1, B_RS2, BR_NONE, MEM_NONE, RS_ALU, 5'b10000);
        addCase(32'h403100b3, 0, ALU_SUB, A_RS1, B_RS2, BR_NONE, MEM_NONE, RS_ALU, 5'b10000);
        addCase(32'h003130b3, 0, 5'h03, A_RS1, B_RS2, BR_NONE, MEM_NONE, RS_ALU, 5'b10000);  // sltu
        addCase(32'h023100b3, 0, 5'h10, A_RS1, B_RS2, BR_NONE, MEM_NONE, RS_ALU, 5'b10000);  // mul
        addCase(32'h023150b3, 0, 5'h15, A_RS1, B_RS2, BR_NONE, MEM_NONE, RS_ALU, 5'b10000);  // divu
        addCase(32'h403100bb, 0, ALU_SUB, A_RS1, B_RS2, BR_NONE, MEM_NONE, RS_ALU, 5'b10100);
        addCase(32'h023100bb, 0, 5'h10, A_RS1, B_RS2, BR_NONE, MEM_NONE, RS_ALU, 5'b10100);  // mulw
        addCase(32'hffb10093, -5, ALU_ADD, A_RS1, B_IMM, BR_NONE, MEM_NONE, RS_ALU, 5'b10000);
        addCase(32'h40715093, 'h407, 5'h0d, A_RS1, B_IMM, BR_NONE, MEM_NONE, RS_ALU, 5'b10000);
        addCase(32'h00315093, 3, 5'h05, A_RS1, B_IMM, BR_NONE, MEM_NONE, RS_ALU, 5'b10000);  // srli
        addCase(32'h03f11093, 'h3f, 5'h01, A_RS1, B_IMM, BR_NONE, MEM_NONE, RS_ALU, 5'b10000);
        addCase(32'hfff17093, -1, 5'h07, A_RS1, B_IMM, BR_NONE, MEM_NONE, RS_ALU, 5'b10000);  // andi
        addCase(32'h4041509b, 'h404, 5'h0d, A_RS1, B_IMM, BR_NONE, MEM_NONE, RS_ALU, 5'b10100);
        addCase(32'hfff1009b, -1, ALU_ADD, A_RS1, B_IMM, BR_NONE, MEM_NONE, RS_ALU, 5'b10100);
        addCase(32'hff010083, -16, ALU_ADD, A_RS1, B_IMM, BR_NONE, MEM_B, RS_MEM, 5'b10000);
        addCase(32'h00813083, 8, ALU_ADD, A_RS1, B_IMM, BR_NONE, MEM_D, RS_MEM, 5'b10000);
        addCase(32'h7ff16083, 'h7ff, ALU_ADD, A_RS1, B_IMM, BR_NONE, MEM_WU, RS_MEM, 5'b10000);
        addCase(32'hfe313c23, -8, ALU_ADD, A_RS1, B_IMM, BR_NONE, MEM_D, RS_ALU, 5'b01000);
        addCase(32'h003102a3, 5, ALU_ADD, A_RS1, B_IMM, BR_NONE, MEM_BU, RS_ALU, 5'b01000);
        addCase(32'h04312023, 'h40, ALU_ADD, A_RS1, B_IMM, BR_NONE, MEM_WU, RS_ALU, 5'b01000);
        addCase(32'h00310863, 16, ALU_SUB, A_RS1, B_RS2, BR_EQ, MEM_NONE, RS_ALU, 5'b00000);
        addCase(32'hfe311ee3, -4, ALU_SUB, A_RS1, B_RS2, BR_NE, MEM_NONE, RS_ALU, 5'b00000);
        addCase(32'h003170e3, 'h800, ALU_SUB, A_RS1, B_RS2, BR_GEU, MEM_NONE, RS_ALU, 5'b00000);
        addCase(32'h800000b7, 64'hffff_ffff_8000_0000, ALU_PASSB, A_PC, B_IMM, BR_NONE,
                MEM_NONE, RS_ALU, 5'b10000);  // lui, upper bit set
        addCase(32'h12345097, 'h12345000, ALU_ADD, A_PC, B_IMM, BR_NONE, MEM_NONE, RS_ALU,
                5'b10000);
        addCase(32'h001000ef, 'h800, ALU_ADD, A_PC, B_FOUR, BR_JAL, MEM_NONE, RS_ALU, 5'b10000);
        addCase(32'hff9ff0ef, -8, ALU_ADD, A_PC, B_FOUR, BR_JAL, MEM_NONE, RS_ALU, 5'b10000);
        addCase(32'h004100e7, 4, ALU_ADD, A_PC, B_FOUR, BR_JALR, MEM_NONE, RS_ALU, 5'b10000);
        addCase(32'h00000073, 0, ALU_ADD, A_PC, B_IMM, BR_NONE, MEM_NONE, RS_CSR, 5'b10010);
        addCase(32'h305110f3, 'h305, ALU_ADD, A_PC, B_IMM, BR_NONE, MEM_NONE, RS_CSR, 5'b10010);
        // bad opcode, bad func7, branch with func3 010
        addCase(32'h0000007f, 0, ALU_ADD, A_PC, B_IMM, BR_NONE, MEM_NONE, RS_ALU, 5'b00001);
        addCase(32'h203100b3, 0, ALU_ADD, A_PC, B_IMM, BR_NONE, MEM_NONE, RS_ALU, 5'b00001);
        addCase(32'h00312863, 0, ALU_ADD, A_PC, B_IMM, BR_NONE, MEM_NONE, RS_ALU, 5'b00001);
    endtask

    task automatic checkOutputs();
        pendT head;
        logic dueNow;
        dueNow = (pending.size() != 0) && (pending[0].due == cycleCount);
        checkField("outValid", 64'(outValid), 64'(dueNow));
        if (outValid) begin
            head    = pending.pop_front();
            seenOut = 1'b1;
            checkField("illegal", 64'(illegal), 64'(head.exp.flags[0]));
            checkField("aluOp", 64'(aluOp), 64'(head.exp.aluOp));
            checkField("aSrc", 64'(aSrc), 64'(head.exp.aSrc));
            checkField("bSrc", 64'(bSrc), 64'(head.exp.bSrc));
            checkField("branch", 64'(branch), 64'(head.exp.branch));
            checkField("regWr", 64'(regWr), 64'(head.exp.flags[4]));
            checkField("memWr", 64'(memWr), 64'(head.exp.flags[3]));
            checkField("memOp", 64'(memOp), 64'(head.exp.memOp));
            checkField("regSrc", 64'(regSrc), 64'(head.exp.regSrc));
            checkField("isTruncate", 64'(isTruncate), 64'(head.exp.flags[2]));
            checkField("isSext", 64'(isSext), 64'(head.exp.flags[2]));
            checkField("intrEn", 64'(intrEn), 64'(head.exp.flags[1]));
            checkField("imm", imm, head.exp.imm);
            checkField("pcOut", pcOut, head.pc);
        end else if (!seenOut) begin
            // flags straight out of reset
            checkField("regWr", 64'(regWr), 64'd0);
            checkField("memWr", 64'(memWr), 64'd0);
            checkField("illegal", 64'(illegal), 64'd0);
            checkField("intrEn", 64'(intrEn), 64'd0);
        end
    endtask

    initial begin
        int   gap;
        pendT p;
        instValid = 1'b0;
        inst      = '0;
        pc        = '0;
        void'($urandom(32'h2e9d71e2));
        buildTable();
        tableReady = 1'b1;
        fork
            forever begin
                @(negedge clk);
                if (!reset) checkOutputs();
            end
        join_none
        wait (reset === 1'b0);
        repeat (3) @(posedge clk);  // quiet stretch after reset
        foreach (cases[i]) begin
            gap = ($urandom % 3 == 0) ? 1 + $urandom % 3 : 0;
            repeat (gap) begin
                @(posedge clk);
                #2;
                instValid = 1'b0;
                inst      = $urandom;  // junk, must not be captured
            end
            @(posedge clk);
            #2;
            p.exp     = cases[i];
            p.pc      = {$urandom, $urandom} & ~64'h3;
            p.due     = cycleCount + 2;
            instValid = 1'b1;
            inst      = cases[i].word;
            pc        = p.pc;
            pending.push_back(p);
        end
        @(posedge clk);
        #2;
        instValid = 1'b0;
        repeat (6) @(negedge clk);  // last result plus a quiet tail with no stray outValid
        if (pending.size() != 0) begin
            failWith("instructions were accepted but never came out");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

    // worst gap is three idle cycles per row
    initial begin
        wait (tableReady);
        repeat (cases.size() * 4 + 50) @(posedge clk);
        failWith("timeout: decoded instructions did not all come out in time");
    end

endmodule
